// File: dataPath.f
hw/aluPkg.sv
hw/dpTypesPkg.sv
hw/regFile.sv
hw/addrRegFile.sv
hw/alu.sv
hw/dataMemory.sv
hw/dataPath.sv
verification/dataPath_chk.sv
verification/dataPathTb.sv

// File: hw/addrRegFile.sv
`timescale 1ns/10ps

module addrRegFile (
    input  logic                                  CLK,
    input  logic                                  rstN_i,
    input  logic                                  we_i,
    input  dpTypesPkg::regFunc_t                  func_i,
    input  logic [dpTypesPkg::NumAddrRegs-1:0]    wrMask_i,
    input  dpTypesPkg::data_t                     wrData_i,
    input  dpTypesPkg::arfSel_t                   outCSel_i,
    input  dpTypesPkg::arfSel_t                   outDSel_i,
    output dpTypesPkg::data_t                     outC_o,
    output dpTypesPkg::addr_t                     outD_o
);

    // Slots PC, AR, SP in wrMask bit order
    dpTypesPkg::data_t regs [dpTypesPkg::NumAddrRegs];

    function automatic dpTypesPkg::data_t readReg(dpTypesPkg::arfSel_t sel);
        case (sel)
            dpTypesPkg::selAR: return regs[dpTypesPkg::ArfArIdx];
            dpTypesPkg::selSP: return regs[dpTypesPkg::ArfSpIdx];
            default:           return regs[dpTypesPkg::ArfPcIdx];
        endcase
    endfunction

    always_ff @(posedge CLK) begin
        if (!rstN_i) begin
            for (int i = 0; i < dpTypesPkg::NumAddrRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            for (int i = 0; i < dpTypesPkg::NumAddrRegs; i++) begin
                if (wrMask_i[i]) begin
                    regs[i] <= dpTypesPkg::stepReg(func_i, regs[i], wrData_i);
                end
            end
        end
    end

    assign outC_o = readReg(outCSel_i);
    assign outD_o = dpTypesPkg::addr_t'(readReg(outDSel_i));  // Memory address

endmodule

// File: hw/alu.sv
`timescale 1ns/10ps

module alu (
    input  logic                 CLK,
    input  logic                 rstN_i,
    input  logic                 we_i,
    input  aluPkg::aluOp_t       op_i,
    input  dpTypesPkg::data_t    a_i,
    input  dpTypesPkg::data_t    b_i,
    output dpTypesPkg::data_t    result_o,
    output aluPkg::aluFlags_t    flags_o
);

    localparam int Msb = dpTypesPkg::DataWidth - 1;

    dpTypesPkg::data_t           result;
    logic [dpTypesPkg::DataWidth:0] sum;
    aluPkg::aluFlags_t           flagsQ;
    aluPkg::aluFlags_t           nextFlags;

    assign sum = {1'b0, a_i} + {1'b0, b_i};

    always_comb begin
        result    = a_i;
        nextFlags = flagsQ;    // Carry and overflow hold by default
        case (op_i)
            aluPkg::opPassA: result = a_i;
            aluPkg::opPassB: result = b_i;
            aluPkg::opNotA:  result = ~a_i;
            aluPkg::opNotB:  result = ~b_i;
            aluPkg::opAdd: begin
                result             = sum[Msb:0];
                nextFlags.carry    = sum[Msb+1];
                nextFlags.overflow = (a_i[Msb] == b_i[Msb]) && (result[Msb] != a_i[Msb]);
            end
            aluPkg::opSub: begin
                result             = a_i - b_i;
                nextFlags.carry    = (a_i < b_i);    // Borrow
                nextFlags.overflow = (a_i[Msb] != b_i[Msb]) && (result[Msb] != a_i[Msb]);
            end
            aluPkg::opMax:   result = (a_i > b_i) ? a_i : b_i;
            aluPkg::opAnd:   result = a_i & b_i;
            aluPkg::opOr:    result = a_i | b_i;
            aluPkg::opNand:  result = ~(a_i & b_i);
            aluPkg::opXor:   result = a_i ^ b_i;
            aluPkg::opLsl, aluPkg::opAsl: begin
                result          = {a_i[Msb-1:0], 1'b0};
                nextFlags.carry = a_i[Msb];
            end
            aluPkg::opLsr: begin
                result          = {1'b0, a_i[Msb:1]};
                nextFlags.carry = a_i[0];
            end
            aluPkg::opAsr: begin
                result          = {a_i[Msb], a_i[Msb:1]};   // Sign kept
                nextFlags.carry = a_i[0];
            end
            aluPkg::opRorc: begin
                // Old carry enters at the top
                result          = {flagsQ.carry, a_i[Msb:1]};
                nextFlags.carry = a_i[0];
            end
            default: result = a_i;
        endcase
        nextFlags.zero     = (result == '0);
        nextFlags.negative = result[Msb];
    end

    always_ff @(posedge CLK) begin
        if (!rstN_i) begin
            flagsQ <= '0;
        end else if (we_i) begin
            flagsQ <= nextFlags;
        end
    end

    assign result_o = result;
    assign flags_o  = flagsQ;

endmodule

// File: hw/aluPkg.sv
package aluPkg;

    localparam int OpWidth = 4;

    // Encodings follow the ALU function select of the original datapath
    typedef enum logic [OpWidth-1:0] {
        opPassA = 4'h0,
        opPassB = 4'h1,
        opNotA  = 4'h2,
        opNotB  = 4'h3,
        opAdd   = 4'h4,
        opSub   = 4'h5,
        opMax   = 4'h6,
        opAnd   = 4'h7,
        opOr    = 4'h8,
        opNand  = 4'h9,
        opXor   = 4'hA,
        opLsl   = 4'hB,
        opLsr   = 4'hC,
        opAsl   = 4'hD,
        opAsr   = 4'hE,
        opRorc  = 4'hF
    } aluOp_t;

    // Z C N O, same bit order as the old flag nibble
    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } aluFlags_t;

endpackage

// File: hw/dataMemory.sv
`timescale 1ns/10ps

module dataMemory (
    input  logic                 CLK,
    input  logic                 we_i,
    input  dpTypesPkg::addr_t    addr_i,
    input  dpTypesPkg::data_t    wrData_i,
    output dpTypesPkg::data_t    rdData_o
);

    localparam int Depth = 2 ** dpTypesPkg::AddrWidth;

    dpTypesPkg::data_t mem [Depth];

    // Asynchronous read
    assign rdData_o = mem[addr_i];

    always_ff @(posedge CLK) begin
        if (we_i) begin
            mem[addr_i] <= wrData_i;
        end
    end

endmodule

// File: hw/dataPath.sv
`timescale 1ns/10ps

module dataPath (
    input  logic                   CLK,
    input  logic                   rstN_i,
    input  logic                   ctrlValid_i,
    input  dpTypesPkg::ctrlWord_t  ctrl_i,
    output dpTypesPkg::data_t      aluOut_o,
    output aluPkg::aluFlags_t      flags_o,
    output dpTypesPkg::addr_t      address_o
);

    dpTypesPkg::data_t rfOutA;
    dpTypesPkg::data_t rfOutB;
    dpTypesPkg::data_t arfOutC;
    dpTypesPkg::addr_t arfOutD;
    dpTypesPkg::data_t memRdData;
    dpTypesPkg::data_t aluResult;
    dpTypesPkg::data_t muxAOut;
    dpTypesPkg::data_t muxBOut;
    dpTypesPkg::data_t muxCOut;

    // Same source set for MuxA and MuxB
    function automatic dpTypesPkg::data_t pickSrc(
        dpTypesPkg::srcSel_t sel,
        dpTypesPkg::data_t   aluVal,
        dpTypesPkg::data_t   memVal,
        dpTypesPkg::data_t   immVal,
        dpTypesPkg::data_t   arfVal
    );
        case (sel)
            dpTypesPkg::srcAlu: return aluVal;
            dpTypesPkg::srcMem: return memVal;
            dpTypesPkg::srcImm: return immVal;
            default:            return arfVal;
        endcase
    endfunction

    assign muxAOut = pickSrc(ctrl_i.muxASel, aluResult, memRdData, ctrl_i.immediate, arfOutC);
    assign muxBOut = pickSrc(ctrl_i.muxBSel, aluResult, memRdData, ctrl_i.immediate, arfOutC);
    assign muxCOut = ctrl_i.muxCSel ? rfOutA : arfOutC;   // ALU A side

    regFile i_regFile (
        .CLK       (CLK),
        .rstN_i    (rstN_i),
        .we_i      (ctrlValid_i),
        .func_i    (ctrl_i.rfFunc),
        .wrMask_i  (ctrl_i.rfWrMask),
        .wrData_i  (muxAOut),
        .outASel_i (ctrl_i.rfOutASel),
        .outBSel_i (ctrl_i.rfOutBSel),
        .outA_o    (rfOutA),
        .outB_o    (rfOutB)
    );

    addrRegFile i_addrRegFile (
        .CLK       (CLK),
        .rstN_i    (rstN_i),
        .we_i      (ctrlValid_i),
        .func_i    (ctrl_i.arfFunc),
        .wrMask_i  (ctrl_i.arfWrMask),
        .wrData_i  (muxBOut),
        .outCSel_i (ctrl_i.arfOutCSel),
        .outDSel_i (ctrl_i.arfOutDSel),
        .outC_o    (arfOutC),
        .outD_o    (arfOutD)
    );

    alu i_alu (
        .CLK      (CLK),
        .rstN_i   (rstN_i),
        .we_i     (ctrlValid_i),
        .op_i     (ctrl_i.aluOp),
        .a_i      (muxCOut),
        .b_i      (rfOutB),
        .result_o (aluResult),
        .flags_o  (flags_o)
    );

    dataMemory i_dataMemory (
        .CLK      (CLK),
        .we_i     (ctrlValid_i & ctrl_i.memWr),   // Write only on a strobe
        .addr_i   (arfOutD),
        .wrData_i (aluResult),
        .rdData_o (memRdData)
    );

    assign aluOut_o  = aluResult;
    assign address_o = arfOutD;

endmodule

// File: hw/dpTypesPkg.sv
package dpTypesPkg;

    localparam int DataWidth   = 8;
    localparam int AddrWidth   = 8;
    localparam int NumGenRegs  = 4;
    localparam int NumAddrRegs = 3;

    // Slot of each address register in wrMask and in the register array
    localparam int ArfPcIdx = 0;
    localparam int ArfArIdx = 1;
    localparam int ArfSpIdx = 2;

    typedef logic [DataWidth-1:0] data_t;
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [$clog2(NumGenRegs)-1:0] regIdx_t;

    typedef enum logic [1:0] {regClear, regLoad, regDec, regInc} regFunc_t;

    // Code 2 was the previous PC, now unused
    typedef enum logic [1:0] {selAR = 2'd0, selSP = 2'd1, selPC = 2'd3} arfSel_t;

    typedef enum logic [1:0] {srcAlu, srcMem, srcImm, srcArf} srcSel_t;

    typedef struct packed {
        regIdx_t                 rfOutASel;
        regIdx_t                 rfOutBSel;
        regFunc_t                rfFunc;
        logic [NumGenRegs-1:0]   rfWrMask;
        aluPkg::aluOp_t          aluOp;
        arfSel_t                 arfOutCSel;
        arfSel_t                 arfOutDSel;
        regFunc_t                arfFunc;
        logic [NumAddrRegs-1:0]  arfWrMask;
        logic                    memWr;
        srcSel_t                 muxASel;
        srcSel_t                 muxBSel;
        logic                    muxCSel;    // 1 picks the register file
        data_t                   immediate;
    } ctrlWord_t;

    // Update rule shared by every register of both files
    function automatic data_t stepReg(regFunc_t func, data_t cur, data_t din);
        case (func)
            regClear: return '0;
            regLoad:  return din;
            regDec:   return cur - 1'b1;
            default:  return cur + 1'b1;
        endcase
    endfunction

endpackage

// File: hw/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic                                 CLK,
    input  logic                                 rstN_i,
    input  logic                                 we_i,
    input  dpTypesPkg::regFunc_t                 func_i,
    input  logic [dpTypesPkg::NumGenRegs-1:0]    wrMask_i,
    input  dpTypesPkg::data_t                    wrData_i,
    input  dpTypesPkg::regIdx_t                  outASel_i,
    input  dpTypesPkg::regIdx_t                  outBSel_i,
    output dpTypesPkg::data_t                    outA_o,
    output dpTypesPkg::data_t                    outB_o
);

    dpTypesPkg::data_t regs [dpTypesPkg::NumGenRegs];

    always_ff @(posedge CLK) begin
        if (!rstN_i) begin
            for (int i = 0; i < dpTypesPkg::NumGenRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            // Several registers may take the same function in one cycle
            for (int i = 0; i < dpTypesPkg::NumGenRegs; i++) begin
                if (wrMask_i[i]) begin
                    regs[i] <= dpTypesPkg::stepReg(func_i, regs[i], wrData_i);
                end
            end
        end
    end

    // Independent read ports
    assign outA_o = regs[outASel_i];
    assign outB_o = regs[outBSel_i];

endmodule

// File: verification/dataPathTb.sv
`timescale 1ns/10ps

module dataPathTb;

    typedef struct packed {
        dpTypesPkg::data_t  res;
        aluPkg::aluFlags_t  flags;
    } refOut_t;

    logic                  CLK = 1'b0;
    logic                  rstN_i;
    logic                  ctrlValid_i;
    dpTypesPkg::ctrlWord_t ctrl_i;
    dpTypesPkg::data_t     aluOut_o;
    aluPkg::aluFlags_t     flags_o;
    dpTypesPkg::addr_t     address_o;

    integer seed = 28;
    int     errors = 0;
    int     checks = 0;
    string  cmpName;
    logic [7:0] cmpExp;
    logic [7:0] cmpAct;
    event   cmpReq;
    dpTypesPkg::data_t gr [4];     // General register model
    dpTypesPkg::data_t ar [3];     // PC, AR, SP
    aluPkg::aluFlags_t expFlags;

    dataPath i_dataPath (.*);

    always #5 CLK = ~CLK;

    // Compare process
    always @(cmpReq) begin
        checks++;
        if (cmpExp !== cmpAct) begin
            errors++;
            $display("mismatch %s expected %h actual %h", cmpName, cmpExp, cmpAct);
        end
    end

    function automatic refOut_t aluRef(aluPkg::aluOp_t op, dpTypesPkg::data_t a,
                                       dpTypesPkg::data_t b, aluPkg::aluFlags_t oldF);
        refOut_t o;
        int      sv;
        o.flags = oldF;
        o.res   = a;
        case (op)
            aluPkg::opPassB: o.res = b;
            aluPkg::opNotA:  o.res = ~a;
            aluPkg::opNotB:  o.res = ~b;
            aluPkg::opAdd: begin
                o.res = a + b;
                o.flags.carry = (int'(a) + int'(b)) > 255;
                sv = int'($signed(a)) + int'($signed(b));
                o.flags.overflow = (sv > 127) || (sv < -128);
            end
            aluPkg::opSub: begin
                o.res = a - b;
                o.flags.carry = a < b;
                sv = int'($signed(a)) - int'($signed(b));
                o.flags.overflow = (sv > 127) || (sv < -128);
            end
            aluPkg::opMax:   o.res = (a > b) ? a : b;
            aluPkg::opAnd:   o.res = a & b;
            aluPkg::opOr:    o.res = a | b;
            aluPkg::opNand:  o.res = ~(a & b);
            aluPkg::opXor:   o.res = a ^ b;
            aluPkg::opLsl, aluPkg::opAsl: begin
                o.res = a << 1;
                o.flags.carry = a[7];
            end
            aluPkg::opLsr, aluPkg::opAsr, aluPkg::opRorc: begin
                o.res = a >> 1;
                if (op == aluPkg::opAsr) o.res[7] = a[7];
                if (op == aluPkg::opRorc) o.res[7] = oldF.carry;
                o.flags.carry = a[0];
            end
            default: o.res = a;
        endcase
        o.flags.zero = (o.res == 8'h00);
        o.flags.negative = o.res[7];
        return o;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $finish;
    endtask

    task automatic checkVal(input string name, input logic [7:0] exp, input logic [7:0] act);
        cmpName = name;
        cmpExp  = exp;
        cmpAct  = act;
        -> cmpReq;
        #0.1;
    endtask

    task automatic waitFall();
        int n;
        n = 0;
        @(CLK);
        while (CLK !== 1'b0 && n < 4) begin
            @(CLK);
            n++;
        end
        if (CLK !== 1'b0) abortRun("timeout waiting for a falling clock edge");
    endtask

    function automatic dpTypesPkg::ctrlWord_t idleCtrl();
        dpTypesPkg::ctrlWord_t c;
        c = '0;
        return c;
    endfunction

    // One strobed control word; returns the combinational ALU output
    task automatic strobe(input dpTypesPkg::ctrlWord_t c, output dpTypesPkg::data_t aluSeen);
        waitFall();
        ctrl_i = c;
        ctrlValid_i = 1'b1;
        #1 aluSeen = aluOut_o;
        waitFall();
        ctrlValid_i = 1'b0;
        ctrl_i = idleCtrl();
    endtask

    task automatic loadGen(input int r, input dpTypesPkg::data_t v);
        dpTypesPkg::ctrlWord_t c;
        dpTypesPkg::data_t     dummy;
        c = idleCtrl();
        c.rfWrMask = 4'b1 << r;
        c.rfFunc = dpTypesPkg::regLoad;
        c.muxASel = dpTypesPkg::srcImm;
        c.immediate = v;
        strobe(c, dummy);
        gr[r] = v;
    endtask

    task automatic loadAddr(input int idx, input dpTypesPkg::data_t v);
        dpTypesPkg::ctrlWord_t c;
        dpTypesPkg::data_t     dummy;
        c = idleCtrl();
        c.arfWrMask = 3'b1 << idx;
        c.arfFunc = dpTypesPkg::regLoad;
        c.muxBSel = dpTypesPkg::srcImm;
        c.immediate = v;
        strobe(c, dummy);
        ar[idx] = v;
    endtask

    // Pass a register through the ALU without a strobe
    task automatic peekGen(input int r, output dpTypesPkg::data_t v);
        ctrl_i = idleCtrl();
        ctrl_i.rfOutASel = r[1:0];
        ctrl_i.muxCSel = 1'b1;
        #1 v = aluOut_o;
    endtask

    task automatic peekAddr(input dpTypesPkg::arfSel_t sel, output dpTypesPkg::data_t viaAlu,
                            output dpTypesPkg::addr_t viaPort);
        ctrl_i = idleCtrl();
        ctrl_i.arfOutCSel = sel;
        ctrl_i.arfOutDSel = sel;
        #1;
        viaAlu = aluOut_o;
        viaPort = address_o;
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        if (errors == errsBefore) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errsBefore);
    endtask

    task automatic checkAllAddr(input string tag);
        dpTypesPkg::data_t v;
        dpTypesPkg::addr_t a;
        peekAddr(dpTypesPkg::selPC, v, a);
        checkVal({tag, " PC"}, ar[0], a);
        checkVal({tag, " PC alu"}, ar[0], v);
        peekAddr(dpTypesPkg::selAR, v, a);
        checkVal({tag, " AR"}, ar[1], a);
        checkVal({tag, " AR alu"}, ar[1], v);
        peekAddr(dpTypesPkg::selSP, v, a);
        checkVal({tag, " SP"}, ar[2], a);
        checkVal({tag, " SP alu"}, ar[2], v);
    endtask

    initial begin
        #200000;
        abortRun("timeout: simulation ran too long");
    end

    initial begin
        dpTypesPkg::ctrlWord_t c;
        dpTypesPkg::data_t     v;
        dpTypesPkg::data_t     a;
        dpTypesPkg::data_t     b;
        aluPkg::aluOp_t        op;
        refOut_t               r;
        int                    e0;
        dpTypesPkg::addr_t     memAddr [4];
        dpTypesPkg::data_t     memExp [4];

        rstN_i = 1'b0;
        ctrlValid_i = 1'b0;
        ctrl_i = idleCtrl();
        for (int i = 0; i < 16; i++) waitFall();
        rstN_i = 1'b1;

        e0 = errors;                                // Reset
        for (int i = 0; i < 4; i++) begin
            gr[i] = 8'h00;
            peekGen(i, v);
            checkVal($sformatf("reset r%0d", i), 8'h00, v);
        end
        for (int i = 0; i < 3; i++) ar[i] = 8'h00;
        checkAllAddr("reset");
        checkVal("reset flags", 8'h00, {4'h0, flags_o});
        reportTest("reset", e0);

        e0 = errors;                                // General registers
        loadGen(0, $random(seed));
        loadGen(1, 8'h00);
        loadGen(2, $random(seed));
        loadGen(3, 8'hFF);
        c = idleCtrl();
        c.rfWrMask = 4'b1101;
        c.rfFunc = dpTypesPkg::regInc;
        strobe(c, v);
        gr[0] = gr[0] + 1;
        gr[2] = gr[2] + 1;
        gr[3] = gr[3] + 1;
        c.rfWrMask = 4'b0010;
        c.rfFunc = dpTypesPkg::regDec;
        strobe(c, v);
        gr[1] = gr[1] - 1;
        for (int i = 0; i < 4; i++) begin
            peekGen(i, v);
            checkVal($sformatf("genreg r%0d", i), gr[i], v);
        end
        reportTest("genreg", e0);

        e0 = errors;                                // ALU sweep
        for (int round = 0; round < 3; round++) begin
            a = $random(seed);
            b = $random(seed);
            loadGen(0, a);
            loadGen(1, b);
            c = idleCtrl();
            c.muxCSel = 1'b1;
            c.rfOutBSel = 2'd1;
            c.aluOp = aluPkg::opAdd;
            strobe(c, v);
            r = aluRef(aluPkg::opAdd, a, b, '0);
            expFlags = r.flags;
            for (int k = 0; k < 16; k++) begin
                op = aluPkg::aluOp_t'(k);
                c.aluOp = op;
                r = aluRef(op, a, b, expFlags);
                strobe(c, v);
                checkVal($sformatf("alu %s result", op.name()), r.res, v);
                checkVal($sformatf("alu %s flags", op.name()), {4'h0, r.flags},
                         {4'h0, flags_o});
                expFlags = r.flags;
            end
        end
        reportTest("alu", e0);

        e0 = errors;                                // Address registers
        loadAddr(1, $random(seed));
        loadAddr(2, 8'hFF);
        loadAddr(0, 8'h00);
        checkAllAddr("addr load");
        c = idleCtrl();
        c.arfWrMask = 3'b010;
        c.arfFunc = dpTypesPkg::regClear;
        strobe(c, v);
        ar[1] = 8'h00;
        c.arfWrMask = 3'b100;
        c.arfFunc = dpTypesPkg::regInc;
        strobe(c, v);
        ar[2] = ar[2] + 1;
        c.arfWrMask = 3'b001;
        c.arfFunc = dpTypesPkg::regDec;
        strobe(c, v);
        ar[0] = ar[0] - 1;
        checkAllAddr("addr step");
        reportTest("addr", e0);

        e0 = errors;                                // Memory
        for (int k = 0; k < 4; k++) begin
            memAddr[k] = 8'h10 + k * 37;
            memExp[k] = $random(seed);
            loadAddr(1, memAddr[k]);
            loadGen(1, memExp[k]);
            c = idleCtrl();
            c.rfOutBSel = 2'd1;
            c.aluOp = aluPkg::opPassB;
            c.arfOutDSel = dpTypesPkg::selAR;
            c.memWr = 1'b1;
            strobe(c, v);
        end
        // All writes land before any read back
        for (int k = 0; k < 4; k++) begin
            loadAddr(1, memAddr[k]);
            c = idleCtrl();
            c.arfOutDSel = dpTypesPkg::selAR;
            c.rfWrMask = 4'b1000;
            c.rfFunc = dpTypesPkg::regLoad;
            c.muxASel = dpTypesPkg::srcMem;
            strobe(c, v);
            gr[3] = memExp[k];
            peekGen(3, v);
            checkVal($sformatf("mem addr %h", memAddr[k]), gr[3], v);
        end
        reportTest("mem", e0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verification/dataPath_chk.sv
`timescale 1ns/10ps

module dataPath_chk (
    input  logic                 CLK,
    input  logic                 rstN_i,
    input  logic                 ctrlValid_i,
    input  dpTypesPkg::data_t    aluOut_i,
    input  aluPkg::aluFlags_t    flags_i
);

    flagsClearAfterReset: assert property (@(posedge CLK) !rstN_i |=> flags_i == '0)
        else $error("flags not clear after reset");

    // Z and N follow the result seen at the strobe
    zeroFollowsResult: assert property (@(posedge CLK) disable iff (!rstN_i)
        ctrlValid_i |=> flags_i.zero == ($past(aluOut_i) == '0))
        else $error("zero flag does not match previous ALU result");

    negFollowsResult: assert property (@(posedge CLK) disable iff (!rstN_i)
        ctrlValid_i |=> flags_i.negative == $past(aluOut_i[7]))
        else $error("negative flag does not match previous ALU result");

endmodule

bind dataPath dataPath_chk i_dataPathChk (
    .CLK         (CLK),
    .rstN_i      (rstN_i),
    .ctrlValid_i (ctrlValid_i),
    .aluOut_i    (aluOut_o),
    .flags_i     (flags_o)
);
